// File: Bender.yml
package:
  name: ntm_input_gate_vector

export_include_dirs:
  - .

sources:
  # Gate vector datapath
  - target: rtl
    files:
      - ntm_gate_pkg.sv
      - ntm_gate_sequencer.sv
      - ntm_gate_lane.sv
      - ntm_gate_logistic.sv
      - ntm_input_gate_vector.sv
  # Testbench with bound assertions
  - target: test
    files:
      - ntm_input_gate_assertions.sv
      - ntm_input_gate_vector_tb.sv

// File: ntm_gate_config.svh
// Build-time sizing only; needs at least 2 lanes, and ACC_W must hold 255 full-scale products
`ifndef NTM_GATE_CONFIG_SVH
`define NTM_GATE_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Signed word, Q8.8 with the fraction below
`define NTM_DATA_W 16
`define NTM_FRAC_W 8    // Fraction bits of every word

// Accumulator width
// 255 products of 2^30 plus a scaled bias stay below 2^39
`define NTM_ACC_W 40

////////////////////////////////////////////////////////////
// Structure
////////////////////////////////////////////////////////////

`define NTM_LANES 4     // Gate elements per run, one lane each
`define NTM_SIZE_W 8    // Term count per run, 1 to 255

`endif

// File: ntm_gate_lane.sv
// One gate element; expects clear and accumulate never together, sum saturates to the Q8.8 range
`timescale 1ns/1ps
`include "ntm_gate_config.svh"

module ntm_gate_lane (
  input  logic                     CLK,
  input  logic                     RST,
  input  ntm_gate_pkg::lane_ctrl_t lane_ctrl,
  input  ntm_gate_pkg::data_t      term_value,
  input  ntm_gate_pkg::data_t      weight,
  input  ntm_gate_pkg::data_t      bias,
  output ntm_gate_pkg::data_t      sum
);

  import ntm_gate_pkg::*;

  // Saturation bounds of a data word, held in accumulator width
  localparam acc_t SUM_MAX = (acc_t'(1) <<< (`NTM_DATA_W - 1)) - acc_t'(1);
  localparam acc_t SUM_MIN = ~SUM_MAX;

  logic signed [2*`NTM_DATA_W-1:0] product;  // Full Q16.16 product
  acc_t acc_q;
  acc_t bias_scaled;
  acc_t rescaled;
  data_t sum_sat;

  ////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////

  assign product     = term_value * weight;
  assign bias_scaled = acc_t'(bias) <<< `NTM_FRAC_W;  // Align bias to product scale
  assign rescaled    = acc_q >>> `NTM_FRAC_W;         // Back to Q8.8, floor

  always_comb begin
    if (rescaled > SUM_MAX) begin
      sum_sat = data_t'(SUM_MAX);
    end else if (rescaled < SUM_MIN) begin
      sum_sat = data_t'(SUM_MIN);
    end else begin
      sum_sat = data_t'(rescaled);
    end
  end

  // Accumulator, restarted by clear on every run
  always_ff @(posedge CLK) begin
    if (lane_ctrl.clear) begin
      acc_q <= bias_scaled;
    end else if (lane_ctrl.accumulate) begin
      acc_q <= acc_q + acc_t'(product);
    end
  end

  // Final sum, stable until the next finish
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (lane_ctrl.finish) begin
      sum <= sum_sat;
    end
  end

endmodule

// File: ntm_gate_logistic.sv
// Hard sigmoid 0.5 + x/4 clamped to 0..1; a finish arriving mid-drain is served after the drain
`timescale 1ns/1ps
`include "ntm_gate_config.svh"

module ntm_gate_logistic (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    finish,
  input  ntm_gate_pkg::data_vec_t sums,
  output logic                    I_OUT_ENABLE,
  output ntm_gate_pkg::data_t     I_OUT,
  output ntm_gate_pkg::lane_idx_t I_OUT_INDEX,
  output logic                    READY
);

  import ntm_gate_pkg::*;

  localparam int SLOPE_SHIFT = 2;  // Slope 1/4, sigmoid slope at 0
  localparam logic signed [`NTM_DATA_W:0] GATE_HALF = 1 <<< (`NTM_FRAC_W - 1);
  localparam logic signed [`NTM_DATA_W:0] GATE_ONE  = 1 <<< `NTM_FRAC_W;
  localparam lane_idx_t LAST_IDX = lane_idx_t'(`NTM_LANES - 1);

  drain_state_t state;
  lane_idx_t    idx;      // Lane being emitted
  logic         pending;  // Another finish seen while draining
  data_vec_t    held;     // Copy of this run's sums
  data_vec_t    src;
  data_t        elem;
  logic signed [`NTM_DATA_W:0] gate_raw;
  data_t        gate_val;

  ////////////////////////////////////////////////////////////
  // Element select and hard sigmoid
  ////////////////////////////////////////////////////////////

  // Lane sums settle on the finish edge, so element 0 reads them live
  assign src  = (idx == '0) ? sums : held;
  assign elem = src[idx];

  assign gate_raw = (elem >>> SLOPE_SHIFT) + GATE_HALF;

  always_comb begin
    if (gate_raw[`NTM_DATA_W]) begin
      gate_val = '0;                  // Below zero
    end else if (gate_raw > GATE_ONE) begin
      gate_val = data_t'(GATE_ONE);   // Above one
    end else begin
      gate_val = data_t'(gate_raw);
    end
  end

  // Snapshot taken with element 0, frees the lanes for the next run
  always_ff @(posedge CLK) begin
    if (state == DRAIN_EMIT && idx == '0) begin
      held <= sums;
    end
  end

  ////////////////////////////////////////////////////////////
  // Drain FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= DRAIN_IDLE;
      idx          <= '0;
      pending      <= 1'b0;
      I_OUT_ENABLE <= 1'b0;
      I_OUT        <= '0;
      I_OUT_INDEX  <= '0;
      READY        <= 1'b0;
    end else begin
      I_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
      case (state)
        DRAIN_IDLE: begin
          if (finish) begin
            state <= DRAIN_EMIT;
            idx   <= '0;
          end
        end

        DRAIN_EMIT: begin
          I_OUT        <= gate_val;
          I_OUT_ENABLE <= 1'b1;
          I_OUT_INDEX  <= idx;
          if (idx == LAST_IDX) begin
            READY   <= 1'b1;        // Rides with the last element
            idx     <= '0;
            pending <= 1'b0;
            if (!(pending || finish)) begin
              state <= DRAIN_IDLE;  // Else restart at once
            end
          end else begin
            idx <= idx + 1'b1;
            if (finish) begin
              pending <= 1'b1;
            end
          end
        end

        default: state <= DRAIN_IDLE;
      endcase
    end
  end

endmodule

// File: ntm_gate_pkg.sv
// Types shared by the gate vector blocks; all widths follow ntm_gate_config.svh
`include "ntm_gate_config.svh"

package ntm_gate_pkg;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  // Signed fixed point word
  typedef logic signed [`NTM_DATA_W-1:0] data_t;

  typedef logic signed [`NTM_ACC_W-1:0] acc_t;   // Lane accumulator
  typedef logic [`NTM_SIZE_W-1:0] size_t;        // Terms in one run

  // Lane number, log2 of the lane count
  typedef logic [$clog2(`NTM_LANES)-1:0] lane_idx_t;

  // One word per lane
  // Weight column, bias set or lane sums
  typedef data_t [`NTM_LANES-1:0] data_vec_t;

  ////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////

  // One dot product beat
  typedef struct packed {
    data_t     value;    // x, r or h element
    data_vec_t weights;  // Matching weight of every lane
  } term_beat_t;

  // Broadcast to every lane
  typedef struct packed {
    logic clear;       // Preload bias
    logic accumulate;  // Add value * weight
    logic finish;      // Rescale, saturate, hold
  } lane_ctrl_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    SEQ_IDLE  = 1'b0,  // Waiting for START
    SEQ_ACCUM = 1'b1   // Taking term beats
  } seq_state_t;

  typedef enum logic {
    DRAIN_IDLE = 1'b0,
    DRAIN_EMIT = 1'b1  // One gate element per cycle
  } drain_state_t;

endpackage

// File: ntm_gate_sequencer.sv
// SIZE_IN must be 1 to 255 (0 never finishes); START mid-run and extra term beats are dropped
`timescale 1ns/1ps

module ntm_gate_sequencer (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  ntm_gate_pkg::size_t      SIZE_IN,
  input  ntm_gate_pkg::data_vec_t  B_IN,
  input  logic                     TERM_IN_ENABLE,
  input  ntm_gate_pkg::term_beat_t TERM_IN,
  output ntm_gate_pkg::lane_ctrl_t lane_ctrl,
  output ntm_gate_pkg::data_t      term_value,
  output ntm_gate_pkg::data_vec_t  weight_col,
  output ntm_gate_pkg::data_vec_t  bias_col
);

  import ntm_gate_pkg::*;

  seq_state_t state;
  size_t      size_q;     // Term count of this run
  size_t      beat_cnt;   // Beats taken so far
  logic       last_beat;  // Final beat went out, finish follows
  logic       start_ok;
  logic       accept;

  ////////////////////////////////////////////////////////////
  // Qualifiers
  ////////////////////////////////////////////////////////////

  assign start_ok = (state == SEQ_IDLE) && START;

  // Count saturates at size_q, later beats fall on the floor
  assign accept = (state == SEQ_ACCUM) && TERM_IN_ENABLE && (beat_cnt != size_q);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= SEQ_IDLE;
      size_q    <= '0;
      beat_cnt  <= '0;
      last_beat <= 1'b0;
      lane_ctrl <= '0;
    end else begin
      // Strobes are single cycle by default
      lane_ctrl.clear      <= 1'b0;
      lane_ctrl.accumulate <= accept;     // Lanes add one edge later
      lane_ctrl.finish     <= last_beat;  // Lanes hold final sum after this
      last_beat            <= accept && (size_t'(beat_cnt + 1'b1) == size_q);

      case (state)
        SEQ_IDLE: begin
          if (start_ok) begin
            state           <= SEQ_ACCUM;
            size_q          <= SIZE_IN;
            beat_cnt        <= '0;
            lane_ctrl.clear <= 1'b1;  // Bias preload on next edge
          end
        end

        SEQ_ACCUM: begin
          if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          // Back to IDLE once finish has been seen by the lanes
          if (lane_ctrl.finish) begin
            state <= SEQ_IDLE;
          end
        end

        default: state <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_ok) begin
      bias_col <= B_IN;  // Held for the whole run
    end
    if (accept) begin
      term_value <= TERM_IN.value;
      weight_col <= TERM_IN.weights;
    end
  end

endmodule

// File: ntm_input_gate_assertions.sv
// Watches the gate output port only; bound into every ntm_input_gate_vector instance
`timescale 1ns/1ps
`include "ntm_gate_config.svh"

module ntm_input_gate_assertions (
  input logic                    CLK,
  input logic                    RST,
  input logic                    I_OUT_ENABLE,
  input ntm_gate_pkg::data_t     I_OUT,
  input ntm_gate_pkg::lane_idx_t I_OUT_INDEX,
  input logic                    READY
);

  import ntm_gate_pkg::*;

  localparam data_t GATE_ONE = data_t'(1 << `NTM_FRAC_W);  // 1.0 in Q8.8

  int fail_cnt = 0;  // Failed checks so far

  ready_with_strobe: assert property (@(posedge CLK) disable iff (RST)
    READY |-> I_OUT_ENABLE)
    else begin
      $error("READY without I_OUT_ENABLE");
      fail_cnt++;
    end

  gate_in_range: assert property (@(posedge CLK) disable iff (RST)
    I_OUT_ENABLE |-> (I_OUT >= 0 && I_OUT <= GATE_ONE))
    else begin
      $error("I_OUT outside 0 to 1.0");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge CLK) RST |-> (!I_OUT_ENABLE && !READY))
    else begin
      $error("Output strobe during reset");
      fail_cnt++;
    end

  // Within a run the next strobe carries the next lane
  index_steps: assert property (@(posedge CLK) disable iff (RST)
    (I_OUT_ENABLE && !READY) |=>
      (I_OUT_ENABLE && I_OUT_INDEX == lane_idx_t'($past(I_OUT_INDEX) + 1'b1)))
    else begin
      $error("I_OUT_INDEX did not step by one");
      fail_cnt++;
    end

endmodule

bind ntm_input_gate_vector ntm_input_gate_assertions assertions_i (
  .CLK          (CLK),
  .RST          (RST),
  .I_OUT_ENABLE (I_OUT_ENABLE),
  .I_OUT        (I_OUT),
  .I_OUT_INDEX  (I_OUT_INDEX),
  .READY        (READY)
);

// File: ntm_input_gate_vector.sv
// Input gate vector top; one term beat per strobe, no back-pressure, lane count fixed at build time
`timescale 1ns/1ps
`include "ntm_gate_config.svh"

module ntm_input_gate_vector (
  input  logic                     CLK,
  input  logic                     RST,

  // Run control
  input  logic                     START,
  input  ntm_gate_pkg::size_t      SIZE_IN,
  input  ntm_gate_pkg::data_vec_t  B_IN,  // Sampled with START

  // Term stream
  input  logic                     TERM_IN_ENABLE,
  input  ntm_gate_pkg::term_beat_t TERM_IN,

  // Gate elements, lane 0 first
  output logic                     I_OUT_ENABLE,
  output ntm_gate_pkg::data_t      I_OUT,
  output ntm_gate_pkg::lane_idx_t  I_OUT_INDEX,
  output logic                     READY
);

  import ntm_gate_pkg::*;

  lane_ctrl_t lane_ctrl;   // Shared by all lanes
  data_t      term_value;
  data_vec_t  weight_col;
  data_vec_t  bias_col;
  data_vec_t  lane_sums;   // Gathered lane results

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  ntm_gate_sequencer seq_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .B_IN           (B_IN),
    .TERM_IN_ENABLE (TERM_IN_ENABLE),
    .TERM_IN        (TERM_IN),
    .lane_ctrl      (lane_ctrl),
    .term_value     (term_value),
    .weight_col     (weight_col),
    .bias_col       (bias_col)
  );

  // One MAC per gate element, own weight and bias slice
  for (genvar g = 0; g < `NTM_LANES; g++) begin : lane_g
    ntm_gate_lane lane_i (
      .CLK        (CLK),
      .RST        (RST),
      .lane_ctrl  (lane_ctrl),
      .term_value (term_value),
      .weight     (weight_col[g]),
      .bias       (bias_col[g]),
      .sum        (lane_sums[g])
    );
  end

  // Finish doubles as the capture pulse
  ntm_gate_logistic logistic_i (
    .CLK          (CLK),
    .RST          (RST),
    .finish       (lane_ctrl.finish),
    .sums         (lane_sums),
    .I_OUT_ENABLE (I_OUT_ENABLE),
    .I_OUT        (I_OUT),
    .I_OUT_INDEX  (I_OUT_INDEX),
    .READY        (READY)
  );

endmodule

// File: ntm_input_gate_vector_tb.sv
// Directed vectors assume 4 lanes in Q8.8; random stimulus is seeded, the run is capped in cycles
`timescale 1ns/1ps
`include "ntm_gate_config.svh"

module ntm_input_gate_vector_tb;

  import ntm_gate_pkg::*;

  localparam int     MAX_CYCLES = 2000;  // About 25 runs of at most 45 cycles, plus margin
  localparam int     LAST       = `NTM_LANES - 1;
  localparam longint ONE        = longint'(1) << `NTM_FRAC_W;
  localparam longint DATA_MAX   = (longint'(1) << (`NTM_DATA_W - 1)) - 1;

  logic       CLK, RST, START, TERM_IN_ENABLE;
  logic       I_OUT_ENABLE, READY;
  size_t      SIZE_IN;
  data_vec_t  B_IN;
  term_beat_t TERM_IN;
  data_t      I_OUT;
  lane_idx_t  I_OUT_INDEX;

  integer     seed = 79;
  int         cycles = 0;
  int         errors = 0;
  int         n_pass = 0;
  int         n_fail = 0;
  int         mark = 0;        // Error count when the current test began
  int         sva_seen = 0;    // Bound checker failures already counted
  int         elem = 0;        // Lane index expected next
  bit         have_exp = 1'b0;
  data_vec_t  expected_q[$];   // One gate vector per run, oldest first
  data_vec_t  cur_exp;
  data_vec_t  bias;
  term_beat_t beats[$];

  ntm_input_gate_vector dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period
  end

  // Hang guard
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  ////////////////////////////////////////////////////////////

  // Gate vector by the fixed-point rule, in 64-bit math
  function automatic data_vec_t expected_gates(input data_vec_t b, input term_beat_t t[$]);
    data_vec_t g;
    longint    acc;
    for (int l = 0; l < `NTM_LANES; l++) begin
      acc = longint'($signed(b[l])) * ONE;  // Bias at product scale
      foreach (t[k]) begin
        acc += longint'($signed(t[k].value)) * longint'($signed(t[k].weights[l]));
      end
      acc = acc >>> `NTM_FRAC_W;                       // Floor to Q8.8
      acc = (acc > DATA_MAX) ? DATA_MAX : acc;
      acc = (acc < -DATA_MAX - 1) ? -DATA_MAX - 1 : acc;
      acc = (acc >>> 2) + ONE / 2;                     // 0.5 + x/4
      acc = (acc < 0) ? 0 : acc;
      g[l] = data_t'((acc > ONE) ? ONE : acc);
    end
    return g;
  endfunction

  // Values within +-4, weights within +-1.5
  function automatic term_beat_t rand_beat();
    term_beat_t b;
    b.value = data_t'($random(seed) % 1024);
    for (int l = 0; l < `NTM_LANES; l++) begin
      b.weights[l] = data_t'($random(seed) % 384);
    end
    return b;
  endfunction

  // START with biases, then each beat after 0..max_gap idle cycles
  task automatic drive_run(input int max_gap, input bit mid_start);
    int gap;
    @(negedge CLK);
    START   = 1'b1;
    SIZE_IN = size_t'(beats.size());
    B_IN    = bias;
    foreach (beats[k]) begin
      gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
      @(negedge CLK);
      START          = 1'b0;
      TERM_IN_ENABLE = 1'b0;
      repeat (gap) @(negedge CLK);
      TERM_IN_ENABLE = 1'b1;
      TERM_IN        = beats[k];
      if (mid_start && k == 1) begin
        START   = 1'b1;   // Stray START, sequencer is busy
        SIZE_IN = 8'd1;
        B_IN    = ~bias;
      end
    end
    @(negedge CLK);
    START          = 1'b0;
    TERM_IN_ENABLE = 1'b0;
  endtask

  // Random biases and beats, expectation queued ahead of the run
  task automatic random_run(input int size, input int max_gap, input bit mid_start);
    for (int l = 0; l < `NTM_LANES; l++) begin
      bias[l] = data_t'($random(seed) % 512);
    end
    beats.delete();
    repeat (size) beats.push_back(rand_beat());
    expected_q.push_back(expected_gates(bias, beats));
    drive_run(max_gap, mid_start);
    @(negedge CLK);  // Next START hits the first IDLE cycle
  endtask

  // Until every queued run is compared, then room for stray strobes
  task automatic wait_runs();
    while (expected_q.size() != 0 || elem != 0) @(negedge CLK);
    repeat (8) @(negedge CLK);
  endtask

  task automatic close_test(input string name);
    errors   = errors + dut_i.assertions_i.fail_cnt - sva_seen;  // Bound checker failures
    sva_seen = dut_i.assertions_i.fail_cnt;
    if (errors == mark) begin
      n_pass++;
      $display("test %-10s PASS", name);
    end else begin
      n_fail++;
      $display("test %-10s FAIL, %0d errors", name, errors - mark);
    end
    mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Output checker, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && I_OUT_ENABLE) begin
      if (elem == 0) begin
        have_exp = (expected_q.size() != 0);
        if (have_exp) begin
          cur_exp = expected_q.pop_front();
        end else begin
          $display("ERROR: gate output appeared with no run pending");
          errors++;
        end
      end
      if (have_exp && I_OUT !== cur_exp[elem]) begin
        $display("MISMATCH I_OUT lane %0d: got 0x%h expected 0x%h", elem, I_OUT, cur_exp[elem]);
        errors++;
      end
      if (I_OUT_INDEX !== lane_idx_t'(elem)) begin
        $display("MISMATCH I_OUT_INDEX: got 0x%h expected 0x%h", I_OUT_INDEX, elem);
        errors++;
      end
      if (READY !== (elem == LAST)) begin
        $display("ERROR: READY is %b on element %0d, wanted only on the last", READY, elem);
        errors++;
      end
      elem = (elem == LAST) ? 0 : elem + 1;
    end else if (!RST && READY) begin
      $display("ERROR: READY came without an output strobe");
      errors++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    B_IN           = '0;
    TERM_IN_ENABLE = 1'b0;
    TERM_IN        = '0;

    // Outputs quiet through reset and a few cycles after
    for (int c = 0; c < 14; c++) begin
      @(negedge CLK);
      if (I_OUT_ENABLE !== 1'b0 || READY !== 1'b0 || I_OUT !== '0) begin
        $display("MISMATCH reset: I_OUT_ENABLE 0x%h READY 0x%h I_OUT 0x%h expected 0x0",
                 I_OUT_ENABLE, READY, I_OUT);
        errors++;
      end
      RST = (c < 9);  // 10 rising edges in reset
    end
    close_test("reset");

    // Hand-computed, lane 0 sums to zero
    bias = {16'h0000, 16'hFF80, 16'h0080, 16'h0000};  // Lane 3 down to lane 0
    beats.delete();
    beats.push_back({16'h0100, 16'h0100, 16'h0000, 16'h0040, 16'h0000});  // Value 1.0
    beats.push_back({16'h0080, 16'h0100, 16'h0000, 16'h0080, 16'h0000});  // Value 0.5
    beats.push_back({16'hFF00, 16'h0100, 16'h0080, 16'h0000, 16'h0000});  // Value -1.0
    expected_q.push_back({16'h00A0, 16'h0040, 16'h00C0, 16'h0080});
    drive_run(0, 1'b0);
    wait_runs();
    close_test("directed");

    // Sums far past the word range both ways
    bias = {16'h8000, 16'h7FFF, 16'h0000, 16'h0000};
    beats.delete();
    repeat (2) beats.push_back({16'h7FFF, 16'h0000, 16'h0000, 16'h8000, 16'h7FFF});
    expected_q.push_back({16'h0000, 16'h0100, 16'h0000, 16'h0100});
    drive_run(0, 1'b0);
    wait_runs();
    close_test("saturate");

    repeat (20) random_run(1 + $unsigned($random(seed)) % 12, 2, 1'b0);
    wait_runs();
    close_test("random");

    // Back to back runs, the last one with a stray START
    random_run(3, 0, 1'b0);
    random_run(2, 0, 1'b0);
    random_run(4, 0, 1'b1);
    wait_runs();
    close_test("overlap");

    $display("tests: %0d pass, %0d fail, %0d check errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
ntm_gate_pkg.sv
ntm_gate_sequencer.sv
ntm_gate_lane.sv
ntm_gate_logistic.sv
ntm_input_gate_vector.sv
ntm_input_gate_assertions.sv
ntm_input_gate_vector_tb.sv
